// ==== uart_reg_link.f ====
design/uart_link_pkg.sv
design/uart_tx_frame.sv
design/uart_rx_frame.sv
design/uart_cmd_master.sv
design/uart_reg_slave.sv
design/uart_reg_link.sv
tests/uart_reg_link_sva.sv
tests/tb_uart_reg_link.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_uart_reg_link
FILELIST  ?= uart_reg_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_uart_reg_link.sv ====
`timescale 1ns/1ps

module tb_uart_reg_link
  import uart_link_pkg::*;
();

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TRANS  = 32;  // Upper bound on transactions in the whole run
  localparam int WAIT_LIMIT = 4 * FRAME_BITS * CLKS_PER_BIT;

  logic                 clk;
  logic                 rst_n;
  link_cmd_t            cmd;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic [DATA_BITS-1:0] read_data;
  logic                 read_rdy;
  logic                 read_err;

  logic [DATA_BITS-1:0] reg_model [REG_DEPTH];
  int                   error_count;

  uart_reg_link i_uart_reg_link (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  bind uart_reg_link uart_reg_link_sva i_uart_reg_link_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_rdy  (cmd_rdy),
    .read_rdy (read_rdy),
    .m2s      (m2s),
    .s2m      (s2m)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #((NUM_TRANS * 3 * FRAME_BITS * CLKS_PER_BIT + 2000) * CLK_PERIOD);  // Three frames each
    $display("Watchdog expired at %0t ns with %0d errors counted", $time, error_count);
    $display("Result: FAILED");
    $finish;
  end

  task automatic check_byte(input string name, input logic [DATA_BITS-1:0] got,
                            input logic [DATA_BITS-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  function automatic link_cmd_t make_write(input logic [ADDR_BITS-1:0] addr,
                                           input logic [DATA_BITS-1:0] data);
    link_cmd_t c;
    c.wr   = 1'b1;
    c.addr = addr;
    c.data = data;
    return c;
  endfunction

  task automatic wait_cmd_rdy();
    int cycles;
    cycles = 0;
    while (!cmd_rdy && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_rdy)
    begin
      $display("cmd_rdy did not come back within %0d cycles at %0t", WAIT_LIMIT, $time);
      error_count++;
    end
  endtask

  task automatic do_write(input link_cmd_t wr_cmd);
    wait_cmd_rdy();
    cmd     = wr_cmd;
    cmd_vld = 1'b1;
    @(negedge clk);  // Taken at the rising edge in between
    cmd_vld = 1'b0;
    wait_cmd_rdy();
    reg_model[wr_cmd.addr] = wr_cmd.data;
  endtask

  task automatic do_read(input logic [ADDR_BITS-1:0] addr, output logic [DATA_BITS-1:0] data,
                         output logic err);
    int cycles;
    wait_cmd_rdy();
    cmd     = '{wr: 1'b0, addr: addr, data: '0};
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    cycles  = 0;
    while (!read_rdy && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!read_rdy)
    begin
      $display("No reply for a read of address 0x%02h within %0d cycles", addr, WAIT_LIMIT);
      error_count++;
    end
    data = read_data;
    err  = read_err;
  endtask

  task automatic read_expect(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] exp);
    logic [DATA_BITS-1:0] data;
    logic                 err;
    do_read(addr, data, err);
    check_byte("read_data", data, exp);
    check_flag("read_err", err, 1'b0);  // The internal pair never corrupts a frame
  endtask

  task automatic test_after_reset();
    check_flag("cmd_rdy", cmd_rdy, 1'b1);
    check_flag("read_rdy", read_rdy, 1'b0);
    read_expect('0, 8'h00);
    read_expect(ADDR_BITS'(REG_DEPTH - 1), 8'h00);
    read_expect(ADDR_BITS'($urandom), 8'h00);
    read_expect(ADDR_BITS'($urandom), 8'h00);
  endtask

  task automatic test_write_read();
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
    addr = ADDR_BITS'($urandom);
    data = DATA_BITS'($urandom);
    do_write(make_write(addr, data));
    read_expect(addr, data);
  endtask

  task automatic test_independent_addrs();
    logic [ADDR_BITS-1:0] addrs [8];
    logic [ADDR_BITS-1:0] tmp;
    int                   j;
    addrs[0] = '0;
    addrs[1] = ADDR_BITS'(REG_DEPTH - 1);
    for (int i = 2; i < 8; i++)
      addrs[i] = ADDR_BITS'($urandom);
    for (int i = 0; i < 8; i++)
      do_write(make_write(addrs[i], DATA_BITS'($urandom)));
    for (int i = 7; i > 0; i--)
    begin
      j        = $urandom_range(i, 0);  // Shuffle so the read order differs from the writes
      tmp      = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = tmp;
    end
    for (int i = 0; i < 8; i++)
      read_expect(addrs[i], reg_model[addrs[i]]);
  endtask

  task automatic test_overwrite();
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
    addr = ADDR_BITS'($urandom);
    data = DATA_BITS'($urandom);
    do_write(make_write(addr, data));
    do_write(make_write(addr, ~data));
    read_expect(addr, ~data);
  endtask

  task automatic test_holdoff();
    link_cmd_t first_cmd;
    link_cmd_t held_cmd;
    first_cmd = make_write(ADDR_BITS'($urandom), DATA_BITS'($urandom));
    held_cmd  = make_write(first_cmd.addr + 1'b1, ~first_cmd.data);
    wait_cmd_rdy();
    cmd     = first_cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd = held_cmd;  // Stays valid through the whole first transaction
    wait_cmd_rdy();
    @(negedge clk);
    cmd_vld = 1'b0;
    if (cmd_rdy)
    begin
      $display("The held command was not taken once cmd_rdy came back");
      error_count++;
    end
    reg_model[first_cmd.addr] = first_cmd.data;
    reg_model[held_cmd.addr]  = held_cmd.data;
    wait_cmd_rdy();
    read_expect(first_cmd.addr, reg_model[first_cmd.addr]);
    read_expect(held_cmd.addr, reg_model[held_cmd.addr]);
  endtask

  initial
  begin
    error_count  = 0;
    rst_n        = 1'b0;
    cmd_vld      = 1'b0;
    cmd          = '0;
    void'($urandom(61));
    foreach (reg_model[i])
      reg_model[i] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_after_reset();
    test_write_read();
    test_independent_addrs();
    test_overwrite();
    test_holdoff();
    $display("Run complete with %0d errors", error_count);
    if (error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== tests/uart_reg_link_sva.sv ====
`timescale 1ns/1ps

module uart_reg_link_sva
  import uart_link_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic read_rdy,
  input logic m2s,
  input logic s2m
);

  logic [1:0]                                        line;
  logic [1:0][$clog2(FRAME_BITS * CLKS_PER_BIT)-1:0] frame_cnt;  // Zero while the line is idle
  logic [1:0][FRAME_BITS-1:0]                        frame_bits;
  logic [1:0]                                        frame_end;

  assign line = {s2m, m2s};  // Index 0 is m2s and index 1 is s2m

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_cnt <= '0;
      frame_end <= '0;
    end
    else
    begin
      for (int i = 0; i < 2; i++)
      begin
        frame_end[i] <= 1'b0;
        if (frame_cnt[i] == '0)
        begin
          if (!line[i])
            frame_cnt[i] <= 1'b1;  // Falling edge of a start bit
        end
        else if (int'(frame_cnt[i]) == FRAME_BITS * CLKS_PER_BIT - 1)
        begin
          frame_cnt[i] <= '0;
          frame_end[i] <= 1'b1;
        end
        else
          frame_cnt[i] <= frame_cnt[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < 2; i++)
      if (frame_cnt[i] != '0 && int'(frame_cnt[i]) % CLKS_PER_BIT == CLKS_PER_BIT / 2)
        frame_bits[i] <= {line[i], frame_bits[i][FRAME_BITS-1:1]};  // Start bit ends at index 0
  end

  cmd_rdy_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> frame_cnt[0] == '0)
    else $error("cmd_rdy rose while a frame was on m2s");

  read_rdy_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy was high for more than one cycle");

  m2s_frame_ok: assert property (@(posedge clk) disable iff (!rst_n)
    frame_end[0] |-> !frame_bits[0][0] && !(^frame_bits[0][FRAME_BITS-2:1])
                     && frame_bits[0][FRAME_BITS-1])
    else $error("Frame on m2s has a bad start, parity or stop bit");

  s2m_frame_ok: assert property (@(posedge clk) disable iff (!rst_n)
    frame_end[1] |-> !frame_bits[1][0] && !(^frame_bits[1][FRAME_BITS-2:1])
                     && frame_bits[1][FRAME_BITS-1])
    else $error("Frame on s2m has a bad start, parity or stop bit");

endmodule

// ==== design/uart_reg_link.sv ====
`timescale 1ns/1ps

module uart_reg_link
  import uart_link_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  link_cmd_t            cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 read_rdy,
  output logic                 read_err
);

  logic m2s;  // Master to slave
  logic s2m;  // Slave to master

  uart_cmd_master i_uart_cmd_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err),
    .tx        (m2s),
    .rx        (s2m)
  );

  uart_reg_slave i_uart_reg_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (m2s),
    .tx    (s2m)
  );

endmodule

// ==== design/uart_reg_slave.sv ====
`timescale 1ns/1ps

module uart_reg_slave
  import uart_link_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic rx,
  output logic tx
);

  typedef enum logic [1:0] {
    S_ADDR,
    S_WDATA,
    S_GAP,
    S_REPLY
  } slave_state_e;

  slave_state_e         state;
  logic [DATA_BITS-1:0] regs [REG_DEPTH];
  logic [ADDR_BITS-1:0] addr_q;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_start;
  logic                 tx_busy;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_par_err;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_ADDR;
      gap_cnt  <= '0;
      tx_start <= 1'b0;
      for (int i = 0; i < REG_DEPTH; i++)
        regs[i] <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_ADDR:
          if (rx_valid && !rx_par_err)
          begin
            gap_cnt <= '0;
            state   <= rx_data[DATA_BITS-1] ? S_WDATA : S_GAP;  // Top bit is the write flag
          end
        S_WDATA:
          if (rx_valid)
          begin
            if (!rx_par_err)
              regs[addr_q] <= rx_data;
            state <= S_ADDR;  // A bad data byte drops the whole write
          end
        S_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_CNT_W'(GAP_BITS * CLKS_PER_BIT - 1))
          begin
            tx_start <= 1'b1;
            state    <= S_REPLY;
          end
        end
        default:
          if (!tx_busy && !tx_start)
            state <= S_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_ADDR && rx_valid)
      addr_q <= rx_data[ADDR_BITS-1:0];
    if (state == S_GAP)
      tx_byte <= regs[addr_q];
  end

  uart_rx_frame i_uart_rx_frame (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_par_err (rx_par_err)
  );

  uart_tx_frame i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_data  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

endmodule

// ==== design/uart_cmd_master.sv ====
`timescale 1ns/1ps

module uart_cmd_master
  import uart_link_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  link_cmd_t            cmd,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic [DATA_BITS-1:0] read_data,
  output logic                 read_rdy,
  output logic                 read_err,
  output logic                 tx,
  input  logic                 rx
);

  typedef enum logic [2:0] {
    M_IDLE,
    M_ADDR,
    M_GAP,
    M_DATA,
    M_WAIT,
    M_DONE
  } master_state_e;

  master_state_e        state;
  link_cmd_t            cmd_q;
  logic [GAP_CNT_W-1:0] gap_cnt;
  logic [DATA_BITS-1:0] tx_byte;
  logic                 tx_start;
  logic                 tx_busy;
  logic                 tx_done;
  logic [DATA_BITS-1:0] rx_data;
  logic                 rx_valid;
  logic                 rx_par_err;

  assign cmd_rdy = (state == M_IDLE);
  assign tx_done = !tx_busy && !tx_start;  // The start pulse is still on its way into the frame

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= M_IDLE;
      gap_cnt  <= '0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        M_IDLE:
          if (cmd_vld)
          begin
            tx_start <= 1'b1;
            state    <= M_ADDR;
          end
        M_ADDR:
          if (tx_done)
          begin
            gap_cnt <= '0;
            state   <= cmd_q.wr ? M_GAP : M_WAIT;
          end
        M_GAP:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_cnt == GAP_CNT_W'(GAP_BITS * CLKS_PER_BIT - 1))
          begin
            tx_start <= 1'b1;
            state    <= M_DATA;
          end
        end
        M_DATA:
          if (tx_done)
            state <= M_DONE;
        M_WAIT:
          if (rx_valid)
          begin
            read_err <= rx_par_err;
            state    <= M_DONE;
          end
        default:
        begin
          read_rdy <= !cmd_q.wr;  // Rises with cmd_rdy
          state    <= M_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == M_IDLE && cmd_vld)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.wr, cmd.addr};
    end
    else if (state == M_GAP)
      tx_byte <= cmd_q.data;
    if (state == M_WAIT && rx_valid)
      read_data <= rx_data;
  end

  uart_tx_frame i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_data  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_frame i_uart_rx_frame (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .rx_data    (rx_data),
    .rx_valid   (rx_valid),
    .rx_par_err (rx_par_err)
  );

endmodule

// ==== design/uart_rx_frame.sv ====
`timescale 1ns/1ps

module uart_rx_frame
  import uart_link_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic [DATA_BITS-1:0] rx_data,
  output logic                 rx_valid,
  output logic                 rx_par_err
);

  frame_state_e         state;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 bit_tick;

  assign bit_tick = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;  // Line idles high
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      rx_valid   <= 1'b0;
      rx_par_err <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        IDLE:
        begin
          clk_cnt <= '0;
          if (!rx_sync)
            state <= START;
        end
        START:
          if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT / 2 - 1))
          begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? IDLE : DATA;  // A short low pulse is only a glitch
          end
        DATA:
          if (bit_tick)
          begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
              state <= PARITY;
          end
        PARITY:
          if (bit_tick)
          begin
            clk_cnt    <= '0;
            rx_par_err <= (rx_sync != ^rx_data);
            state      <= STOP;
          end
        default:
          // Report once the stop bit has run out
          if (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT + CLKS_PER_BIT / 2 - 1))
          begin
            rx_valid <= 1'b1;
            state    <= IDLE;
          end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == DATA && bit_tick)
      rx_data <= {rx_sync, rx_data[DATA_BITS-1:1]};  // Bits arrive LSB first
  end

endmodule

// ==== design/uart_tx_frame.sv ====
`timescale 1ns/1ps

module uart_tx_frame
  import uart_link_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [DATA_BITS-1:0] tx_data,
  input  logic                 tx_start,
  output logic                 tx_busy,
  output logic                 tx
);

  frame_state_e         state;
  logic [CLK_CNT_W-1:0] clk_cnt;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic [DATA_BITS-1:0] shreg;
  logic                 par_bit;
  logic                 bit_tick;

  assign bit_tick = (clk_cnt == CLK_CNT_W'(CLKS_PER_BIT - 1));
  assign tx_busy  = (state != IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
    end
    else if (state == IDLE)
    begin
      clk_cnt <= '0;
      if (tx_start)
        state <= START;
    end
    else if (!bit_tick)
      clk_cnt <= clk_cnt + 1'b1;
    else
    begin
      clk_cnt <= '0;
      case (state)
        START:
        begin
          bit_idx <= '0;
          state   <= DATA;
        end
        DATA:
        begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == BIT_IDX_W'(DATA_BITS - 1))
            state <= PARITY;
        end
        PARITY:  state <= STOP;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && tx_start)
    begin
      shreg   <= tx_data;
      par_bit <= ^tx_data;  // Even parity over the data byte
    end
    else if (state == DATA && bit_tick)
      shreg <= shreg >> 1;  // LSB goes out first
  end

  always_comb
  begin
    case (state)
      START:   tx = 1'b0;
      DATA:    tx = shreg[0];
      PARITY:  tx = par_bit;
      default: tx = 1'b1;
    endcase
  end

endmodule

// ==== design/uart_link_pkg.sv ====
package uart_link_pkg;

  localparam int DATA_BITS    = 8;
  localparam int ADDR_BITS    = 7;
  localparam int FRAME_BITS   = 11;  // Start, eight data, parity and stop
  localparam int CLKS_PER_BIT = 16;
  localparam int GAP_BITS     = 2;   // Idle bit-times between bytes
  localparam int REG_DEPTH    = 128;

  localparam int CLK_CNT_W = $clog2(2 * CLKS_PER_BIT);  // Room for the stop bit and a half
  localparam int GAP_CNT_W = $clog2(GAP_BITS * CLKS_PER_BIT);
  localparam int BIT_IDX_W = $clog2(DATA_BITS);

  typedef struct packed {
    logic                 wr;
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] data;
  } link_cmd_t;

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } frame_state_e;

endpackage
